// File: hdl/div_pkg.sv
// shared widths, types and operation codes of the RV64M divide unit
// width fixed at 64 by the instruction set
package div_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0]   xword_t;  // operand, quotient, remainder, result
    typedef logic [2*xlen-1:0] dword_t;  // remainder:quotient working register
    typedef logic [2:0]        div_op_t;
    typedef logic [5:0]        iter_cnt_t;

    // bit 2 word, bit 1 remainder, bit 0 unsigned
    localparam div_op_t op_div   = 3'd0;
    localparam div_op_t op_divu  = 3'd1;
    localparam div_op_t op_rem   = 3'd2;
    localparam div_op_t op_remu  = 3'd3;
    localparam div_op_t op_divw  = 3'd4;
    localparam div_op_t op_divuw = 3'd5;
    localparam div_op_t op_remw  = 3'd6;
    localparam div_op_t op_remuw = 3'd7;

    typedef enum logic {
        core_idle,
        core_run
    } core_state_e;

endpackage

// File: hdl/div_core_if.sv
// operand request and quotient/remainder response of the divider core
// start and done are single-cycle pulses; results hold until the next start
interface div_core_if;
    import div_pkg::*;

    logic   start;
    xword_t dividend;
    xword_t divisor;
    logic   done;
    xword_t quotient;
    xword_t remainder;

    modport req (
        output start,
        output dividend,
        output divisor
    );

    modport core (
        input  start,
        input  dividend,
        input  divisor,
        output done,
        output quotient,
        output remainder
    );

    modport rsp (
        input done,
        input quotient,
        input remainder
    );

endinterface

// File: hdl/div_ctl_if.sv
// sign and selection flags from the operand stage to the result stage
// flags are stable from the launch of a division until the next launch
interface div_ctl_if;

    logic neg_quot;  // already cleared on divide by zero
    logic neg_rem;
    logic word_op;
    logic rem_sel;

    modport src (
        output neg_quot,
        output neg_rem,
        output word_op,
        output rem_sel
    );

    modport dst (
        input neg_quot,
        input neg_rem,
        input word_op,
        input rem_sel
    );

endinterface

// File: hdl/div_operand_prep.sv
// start is sampled only while busy is low; op and operands are valid with start
// busy drops in the done cycle so the next start can be accepted there
module div_operand_prep (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  div_pkg::div_op_t op,
    input  div_pkg::xword_t  rs1,
    input  div_pkg::xword_t  rs2,
    input  logic             finish,
    output logic             busy,
    div_core_if.req          core,
    div_ctl_if.src           ctl
);
    import div_pkg::*;

    logic   busy_q;
    logic   accept;
    logic   is_word;
    logic   is_rem;
    logic   is_uns;
    xword_t op_a;
    xword_t op_b;
    logic   neg_a;
    logic   neg_b;
    xword_t abs_a;
    xword_t abs_b;

    assign is_word = op[2];
    assign is_rem  = op[1];
    assign is_uns  = op[0];

    assign busy   = busy_q & ~finish;  // free again in the done cycle
    assign accept = start & ~busy;

    always_comb begin
        if (!is_word) begin
            op_a = rs1;
            op_b = rs2;
        end else if (is_uns) begin
            op_a = {32'b0, rs1[31:0]};
            op_b = {32'b0, rs2[31:0]};
        end else begin
            op_a = {{32{rs1[31]}}, rs1[31:0]};
            op_b = {{32{rs2[31]}}, rs2[31:0]};
        end
    end

    assign neg_a = ~is_uns & op_a[xlen-1];
    assign neg_b = ~is_uns & op_b[xlen-1];
    assign abs_a = neg_a ? (~op_a + 1'b1) : op_a;
    assign abs_b = neg_b ? (~op_b + 1'b1) : op_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q       <= 1'b0;
            core.start   <= 1'b0;
            ctl.neg_quot <= 1'b0;
            ctl.neg_rem  <= 1'b0;
            ctl.word_op  <= 1'b0;
            ctl.rem_sel  <= 1'b0;
        end else begin
            core.start <= accept;
            if (accept) begin
                busy_q       <= 1'b1;
                ctl.neg_quot <= (neg_a ^ neg_b) & (op_b != '0);
                ctl.neg_rem  <= neg_a;
                ctl.word_op  <= is_word;
                ctl.rem_sel  <= is_rem;
            end else if (finish) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            core.dividend <= abs_a;
            core.divisor  <= abs_b;
        end
    end

endmodule

// File: hdl/div_core.sv
// unsigned radix-2 restoring divider, 64 iterations, first one on the load edge
// quotient and remainder hold after done until the next start
module div_core (
    input  logic     clk,
    input  logic     rst_n,
    div_core_if.core bus
);
    import div_pkg::*;

    core_state_e state;
    iter_cnt_t   cnt;
    dword_t      work;     // remainder high, quotient low
    xword_t      divisor_q;
    logic        last;

    // shift left, then subtract where the upper half allows
    function automatic dword_t div_step(input dword_t w, input xword_t d);
        dword_t s;
        s = w << 1;
        if (s[2*xlen-1:xlen] >= d) begin
            s[2*xlen-1:xlen] = s[2*xlen-1:xlen] - d;
            s[0]             = 1'b1;
        end
        return s;
    endfunction

    assign last = (cnt == iter_cnt_t'(xlen - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= core_idle;
            cnt      <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            case (state)
                core_idle: begin
                    if (bus.start) begin
                        state <= core_run;
                        cnt   <= iter_cnt_t'(1);  // load edge counts as one
                    end
                end
                core_run: begin
                    cnt <= cnt + 1'b1;
                    if (last) begin
                        state    <= core_idle;
                        bus.done <= 1'b1;
                    end
                end
                default: state <= core_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_idle && bus.start) begin
            work      <= div_step({{xlen{1'b0}}, bus.dividend}, bus.divisor);
            divisor_q <= bus.divisor;
        end else if (state == core_run) begin
            work <= div_step(work, divisor_q);
        end
    end

    assign bus.quotient  = work[xlen-1:0];
    assign bus.remainder = work[2*xlen-1:xlen];

endmodule

// File: hdl/div_result_fix.sv
// sign correction and selection of the core result, registered on core done
// result holds between done pulses
module div_result_fix (
    input  logic            clk,
    input  logic            rst_n,
    div_core_if.rsp         bus,
    div_ctl_if.dst          ctl,
    output div_pkg::xword_t result,
    output logic            done
);
    import div_pkg::*;

    xword_t quot_fix;
    xword_t rem_fix;
    xword_t sel;
    xword_t ext;

    assign quot_fix = ctl.neg_quot ? (~bus.quotient + 1'b1) : bus.quotient;
    assign rem_fix  = ctl.neg_rem ? (~bus.remainder + 1'b1) : bus.remainder;
    assign sel      = ctl.rem_sel ? rem_fix : quot_fix;

    // word results always sign-extend bit 31, unsigned forms too
    assign ext = ctl.word_op ? {{32{sel[31]}}, sel[31:0]} : sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= bus.done;
            if (bus.done) begin
                result <= ext;
            end
        end
    end

endmodule

// File: hdl/div_unit.sv
// RV64M divide unit, one division in flight, fixed latency of 65 cycles
// start while busy is ignored; no back-pressure, result held until next done
module div_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  div_pkg::div_op_t op,
    input  div_pkg::xword_t  rs1,
    input  div_pkg::xword_t  rs2,
    output logic             busy,
    output logic             done,
    output div_pkg::xword_t  result
);

    div_core_if core_bus ();
    div_ctl_if  ctl_bus ();

    div_operand_prep i_prep (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .rs1    (rs1),
        .rs2    (rs2),
        .finish (done),  // registered done frees busy
        .busy   (busy),
        .core   (core_bus.req),
        .ctl    (ctl_bus.src)
    );

    div_core i_core (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (core_bus.core)
    );

    div_result_fix i_fix (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (core_bus.rsp),
        .ctl    (ctl_bus.dst),
        .result (result),
        .done   (done)
    );

endmodule

// File: bench/div_checker.sv
// watches the divide unit ports, expects done exactly latency edges after the accepting edge
// reference results follow the RISC-V M rules for divide by zero and signed overflow
module div_checker #(
    parameter int latency = 65
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  div_pkg::div_op_t op,
    input  div_pkg::xword_t  rs1,
    input  div_pkg::xword_t  rs2,
    input  logic             busy,
    input  logic             done,
    input  div_pkg::xword_t  result,
    output int               value_errs,
    output int               timing_errs,
    output int               checked
);
    timeunit 1ns;
    timeprecision 100ps;
    import div_pkg::*;

    int      n_value = 0;
    int      n_timing = 0;
    int      n_checked = 0;
    logic    pending = 1'b0;
    int      edges = 0;
    div_op_t cap_op;
    xword_t  cap_a;
    xword_t  cap_b;
    xword_t  last_result = '0;

    assign value_errs  = n_value;
    assign timing_errs = n_timing;
    assign checked     = n_checked;

    function automatic xword_t ref_result(input div_op_t o, input xword_t a, input xword_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic signed [31:0] wq;
        logic signed [31:0] wr;
        logic [31:0]        w;
        xword_t             r;
        logic               ovf64;
        logic               ovf32;
        sa    = a;
        sb    = b;
        wa    = a[31:0];
        wb    = b[31:0];
        ovf64 = (a == 64'h8000_0000_0000_0000) && (b == '1);
        ovf32 = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
        sq    = '0;
        sr    = '0;
        wq    = '0;
        wr    = '0;
        // signed quotients in signed context of their own
        if (!ovf64 && b != '0) begin
            sq = sa / sb;
            sr = sa % sb;
        end
        if (!ovf32 && b[31:0] != '0) begin
            wq = wa / wb;
            wr = wa % wb;
        end
        w     = '0;
        r     = '0;
        case (o)
            op_div:   r = (b == '0) ? '1 : (ovf64 ? a : sq);
            op_divu:  r = (b == '0) ? '1 : a / b;
            op_rem:   r = (b == '0) ? a : (ovf64 ? '0 : sr);
            op_remu:  r = (b == '0) ? a : a % b;
            op_divw:  w = (wb == 0) ? '1 : (ovf32 ? wa : wq);
            op_divuw: w = (b[31:0] == '0) ? '1 : a[31:0] / b[31:0];
            op_remw:  w = (wb == 0) ? wa : (ovf32 ? '0 : wr);
            default:  w = (b[31:0] == '0) ? a[31:0] : a[31:0] % b[31:0];
        endcase
        if (o[2]) begin
            r = {{32{w[31]}}, w};  // word results always sign-extended
        end
        return r;
    endfunction

    always @(negedge clk) begin
        xword_t expected;
        if (!rst_n) begin
            pending     = 1'b0;
            edges       = 0;
            last_result = '0;  // result must come out of reset as zero
        end else begin
            if (pending) begin
                edges = edges + 1;  // accepting edge counts as the first
                if (done !== (edges == latency + 1)) begin
                    $display("ERR %0t: done is %b, %0d edges after accept", $time, done, edges);
                    n_timing++;
                end
                if (busy !== (edges <= latency)) begin
                    $display("ERR %0t: busy is %b, %0d edges after accept", $time, busy, edges);
                    n_timing++;
                end
                if (edges == latency + 1) begin
                    pending  = 1'b0;
                    expected = ref_result(cap_op, cap_a, cap_b);
                    n_checked++;
                    if (result !== expected) begin
                        $display("ERR %0t: op %0d rs1 %h rs2 %h expected %h got %h",
                                 $time, cap_op, cap_a, cap_b, expected, result);
                        n_value++;
                    end
                end
            end else if (done !== 1'b0 || busy !== 1'b0) begin
                $display("ERR %0t: done %b busy %b with no division running", $time, done, busy);
                n_timing++;
            end
            if (done !== 1'b1 && result !== last_result) begin
                $display("ERR %0t: result changed between done pulses", $time);
                n_value++;
            end
            last_result = result;
            if (start === 1'b1 && busy === 1'b0) begin
                pending = 1'b1;
                edges   = 0;
                cap_op  = op;
                cap_a   = rs1;
                cap_b   = rs2;
            end
        end
    end

endmodule

// File: bench/tb_div_unit.sv
// drives the divide unit 1 ns after each rising edge, one division at a time
// directed divide by zero and overflow cases first, then biased random operands
module tb_div_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import div_pkg::*;

    localparam int          num_tests  = 400;
    localparam int          n_directed = 14;
    localparam int          clk_period = 10;
    localparam int          latency    = 65;
    localparam logic [31:0] seed       = 32'hb88cf2e9;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    start;
    div_op_t op;
    xword_t  rs1;
    xword_t  rs2;
    logic    busy;
    logic    done;
    xword_t  result;
    int      value_errs;
    int      timing_errs;
    int      checked;
    int      stim_errs;

    div_unit i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .rs1    (rs1),
        .rs2    (rs2),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    div_checker #(.latency(latency)) i_chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .busy        (busy),
        .done        (done),
        .result      (result),
        .value_errs  (value_errs),
        .timing_errs (timing_errs),
        .checked     (checked)
    );

    always #(clk_period / 2) clk = ~clk;

    // zero, minus one, most negative and small values show up often
    function automatic xword_t rand_operand();
        xword_t v;
        case ($urandom % 10)
            0:       v = '0;
            1:       v = '1;
            2:       v = 64'h8000_0000_0000_0000;
            3:       v = xword_t'($urandom % 16);
            4:       v = -xword_t'($urandom % 16);
            5:       v = {$urandom, 32'h8000_0000};  // word most negative, junk above
            6:       v = {$urandom, 32'hffff_ffff};
            default: v = {$urandom, $urandom} >> ($urandom % 64);
        endcase
        return v;
    endfunction

    task automatic get_directed(input int idx, output div_op_t o, output xword_t a,
                                output xword_t b);
        o = div_op_t'(idx % 8);
        a = rand_operand();
        b = o[2] ? 64'hdead_beef_0000_0000 : '0;  // zero low word for word forms
        case (idx)
            8:  begin o = op_div;   a = 64'h8000_0000_0000_0000; b = '1; end
            9:  begin o = op_rem;   a = 64'h8000_0000_0000_0000; b = '1; end
            10: begin o = op_divw;  a = 64'h1234_5678_8000_0000; b = 64'hffff_ffff; end
            11: begin o = op_remw;  a = 64'h1234_5678_8000_0000; b = 64'hffff_ffff; end
            12: begin o = op_divuw; a = 64'hffff_fff0; b = 64'h5555_5555_0000_0001; end
            13: begin o = op_remuw; a = 64'h8000_0005; b = 64'h8000_0006; end
            default: ;
        endcase
    endtask

    task automatic run_op(input div_op_t o, input xword_t a, input xword_t b);
        int n;
        start = 1'b1;
        op    = o;
        rs1   = a;
        rs2   = b;
        @(posedge clk);
        #1;
        start = 1'b0;
        op    = div_op_t'($urandom % 8);  // don't care without start
        rs1   = rand_operand();
        rs2   = rand_operand();
        if ($urandom % 4 == 0) begin
            repeat (1 + $urandom % 50) begin
                @(posedge clk);
                #1;
            end
            start = 1'b1;  // must be ignored while busy
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        n = 0;
        while (done !== 1'b1 && n < 2 * latency) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (done !== 1'b1) begin
            $display("no done seen within %0d cycles of a start", 2 * latency);
            stim_errs++;
        end else if ($urandom % 3 != 0) begin
            // otherwise the next start lands in the done cycle
            repeat (1 + $urandom % 3) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial begin
        repeat (num_tests * 80 + 1000) @(posedge clk);
        $display("run timed out after %0d cycles", num_tests * 80 + 1000);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        div_op_t o;
        xword_t  a;
        xword_t  b;
        void'($urandom(seed));
        rst_n     = 1'b0;
        start     = 1'b0;
        op        = '0;
        rs1       = '0;
        rs2       = '0;
        stim_errs = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < num_tests; i++) begin
            if (i < n_directed) begin
                get_directed(i, o, a, b);
            end else begin
                o = div_op_t'($urandom % 8);
                a = rand_operand();
                b = rand_operand();
            end
            run_op(o, a, b);
        end
        repeat (3) @(posedge clk);
        $display("%0d of %0d results checked, %0d value errors, %0d timing errors, %0d stalls",
                 checked, num_tests, value_errs, timing_errs, stim_errs);
        if (value_errs == 0 && timing_errs == 0 && stim_errs == 0 && checked == num_tests) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/div_pkg.sv
hdl/div_core_if.sv
hdl/div_ctl_if.sv
hdl/div_operand_prep.sv
hdl/div_core.sv
hdl/div_result_fix.sv
hdl/div_unit.sv
bench/div_checker.sv
bench/tb_div_unit.sv

// File: run.sh
#!/bin/sh
# builds and runs the divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    -f project.f --top-module tb_div_unit -o sim_div

./obj_dir/sim_div | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0
